//--- test/pcc_stimulus.txt
# stall branch branch_pc syscall kret csr_we csr_waddr csr_wdata csr_raddr
#   then expected pc fetch_ok mode_kernel csr_rdata after the capturing edge (all hex)
0 0 000000000000 0 0 0 00 000000 12 000000000001 1 1 001000
0 0 000000000000 0 0 0 00 000000 00 000000000002 1 1 000001
0 0 000000000000 0 0 0 00 000000 14 000000000003 1 1 000003
1 0 000000000000 0 0 0 00 000000 14 000000000003 1 1 000003
1 1 000000000100 0 0 0 00 000000 14 000000000100 1 1 000100
0 0 000000000000 0 0 0 00 000000 14 000000000101 1 1 000101
0 1 000000001000 0 0 0 00 000000 14 000000001000 0 1 001000
0 0 000000000000 0 0 0 00 000000 15 000000001000 0 1 000000
0 0 000000000000 0 0 1 10 002000 10 000000001000 0 1 002000
0 0 000000000000 0 0 1 12 000100 12 000000001000 0 1 000100
0 1 000000002080 0 0 0 00 000000 14 000000002080 1 1 002080
0 0 000000000000 0 0 0 00 000000 14 000000002081 1 1 002081
0 0 000000000000 0 0 1 16 000000 16 000000002082 0 1 000000
0 0 000000000000 0 0 1 16 000004 16 000000002082 1 1 000004
0 0 000000000000 0 0 1 17 000000 17 000000002083 0 1 000000
0 0 000000000000 0 0 1 17 000001 17 000000002083 1 1 000001
1 0 000000000000 0 0 1 14 123456 14 000000002083 1 1 002083
1 0 000000000000 0 1 0 00 000000 00 000000002083 1 0 000000
1 0 000000000000 1 0 0 00 000000 00 000000002083 1 1 000001
1 0 000000000000 0 0 1 00 000000 00 000000002083 1 0 000000
1 0 000000000000 0 0 1 10 000000 10 000000002083 1 0 002000
1 0 000000000000 0 0 1 16 000000 16 000000002083 1 0 000004
1 0 000000000000 0 0 1 00 000001 00 000000002083 1 0 000000
0 0 000000000000 0 0 0 00 000000 14 000000002084 1 0 002084
0 1 000123002090 0 0 0 00 000000 15 000123002090 0 0 000123
0 0 000000000000 0 0 0 00 000000 14 000123002090 0 0 002090
1 0 000000000000 1 0 0 00 000000 00 000123002090 0 1 000001
1 0 000000000000 0 1 1 00 000001 00 000123002090 0 0 000000
1 0 000000000000 0 0 0 00 000000 13 000123002090 0 0 000000
1 0 000000000000 0 0 0 00 000000 20 000123002090 0 0 000000

//--- sim.f
rtl/amber_pcc_pkg.sv
rtl/priv_mode_fsm.sv
rtl/fetch_pc_counter.sv
rtl/pcc_window.sv
rtl/amber_fetch_top.sv
test/tb_amber_fetch.sv

//--- test/tb_amber_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_amber_fetch;

    localparam int MAX_CYCLES = 256;

    logic                    iw_clk;
    logic                    iw_rst;
    logic                    stall;
    logic                    branch_taken;
    amber_pcc_pkg::addr_t    branch_pc;
    logic                    syscall;
    logic                    kret;
    logic                    csr_we;
    amber_pcc_pkg::csr_idx_t csr_waddr;
    amber_pcc_pkg::data_t    csr_wdata;
    amber_pcc_pkg::csr_idx_t csr_raddr;
    amber_pcc_pkg::addr_t    pc;
    logic                    fetch_ok;
    logic                    mode_kernel;
    amber_pcc_pkg::data_t    csr_rdata;

    int cycle_no;

    amber_fetch_top uut (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .stall       (stall),
        .branch_taken(branch_taken),
        .branch_pc   (branch_pc),
        .syscall     (syscall),
        .kret        (kret),
        .csr_we      (csr_we),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata),
        .csr_raddr   (csr_raddr),
        .pc          (pc),
        .fetch_ok    (fetch_ok),
        .mode_kernel (mode_kernel),
        .csr_rdata   (csr_rdata)
    );

    // 20 ns period
    always #10 iw_clk = ~iw_clk;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_output(input string name, input logic [47:0] expected,
                                  input logic [47:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s in cycle %0d: expected %h, got %h",
                     name, cycle_no, expected, actual);
            abort_run();
        end
    endtask

    // ------------------------------
    // One stimulus cycle
    // ------------------------------
    // Inputs land on one edge and are captured on the next; the stall
    // driven afterwards keeps the state still while the outputs are checked
    task automatic run_cycle(input logic s_stall, input logic s_branch,
                             input logic [47:0] s_branch_pc, input logic s_syscall,
                             input logic s_kret, input logic s_we,
                             input logic [7:0] s_waddr, input logic [23:0] s_wdata,
                             input logic [7:0] s_raddr, input logic [47:0] e_pc,
                             input logic e_ok, input logic e_mode,
                             input logic [23:0] e_rdata);
        @(posedge iw_clk);
        stall        <= s_stall;
        branch_taken <= s_branch;
        branch_pc    <= s_branch_pc;
        syscall      <= s_syscall;
        kret         <= s_kret;
        csr_we       <= s_we;
        csr_waddr    <= s_waddr;
        csr_wdata    <= s_wdata;
        csr_raddr    <= s_raddr;
        @(posedge iw_clk);
        stall        <= 1'b1;
        branch_taken <= 1'b0;
        syscall      <= 1'b0;
        kret         <= 1'b0;
        csr_we       <= 1'b0;
        @(negedge iw_clk);
        compare_output("pc", e_pc, pc);
        compare_output("fetch_ok", e_ok, fetch_ok);
        compare_output("mode_kernel", e_mode, mode_kernel);
        compare_output("csr_rdata", e_rdata, csr_rdata);
    endtask

    // ------------------------------
    // Stimulus file replay
    // ------------------------------
    task automatic replay_file(input int fd);
        string       line;
        int          n_fields;
        logic        done;
        logic        s_stall;
        logic        s_branch;
        logic [47:0] s_branch_pc;
        logic        s_syscall;
        logic        s_kret;
        logic        s_we;
        logic [7:0]  s_waddr;
        logic [23:0] s_wdata;
        logic [7:0]  s_raddr;
        logic [47:0] e_pc;
        logic        e_ok;
        logic        e_mode;
        logic [23:0] e_rdata;
        done = 1'b0;
        while (!done) begin
            if ($fgets(line, fd) == 0) begin
                done = 1'b1;
            end else if (line.len() > 1 && line.getc(0) != "#") begin
                if (cycle_no >= MAX_CYCLES) begin
                    $display("Error: stimulus file holds more than %0d cycles",
                             MAX_CYCLES);
                    abort_run();
                end else begin
                    cycle_no++;
                    n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                       s_stall, s_branch, s_branch_pc, s_syscall, s_kret,
                                       s_we, s_waddr, s_wdata, s_raddr,
                                       e_pc, e_ok, e_mode, e_rdata);
                    if (n_fields != 13) begin
                        $display("Error: stimulus line for cycle %0d is not 13 hex fields",
                                 cycle_no);
                        abort_run();
                    end else begin
                        run_cycle(s_stall, s_branch, s_branch_pc, s_syscall, s_kret,
                                  s_we, s_waddr, s_wdata, s_raddr, e_pc, e_ok, e_mode,
                                  e_rdata);
                    end
                end
            end
        end
    endtask

    initial begin
        int fd;
        iw_clk       = 1'b0;
        iw_rst       = 1'b1;
        // Stall stays high until the first stimulus line so the PC sits at 0
        stall        = 1'b1;
        branch_taken = 1'b0;
        branch_pc    = '0;
        syscall      = 1'b0;
        kret         = 1'b0;
        csr_we       = 1'b0;
        csr_waddr    = '0;
        csr_wdata    = '0;
        csr_raddr    = '0;
        cycle_no     = 0;
        fd = $fopen("test/pcc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open the stimulus file test/pcc_stimulus.txt");
            abort_run();
        end else begin
            repeat (16) @(posedge iw_clk);
            iw_rst <= 1'b0;
            replay_file(fd);
            $fclose(fd);
            if (cycle_no == 0) begin
                $display("Error: stimulus file holds no cycles");
                abort_run();
            end else begin
                $display("Simulation completed successfully");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/amber_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module amber_fetch_top #(
    parameter int unsigned PCC_RESET_LEN = 4096
) (
    input  wire                           iw_clk,
    input  wire                           iw_rst,
    input  wire logic                     stall,
    input  wire logic                     branch_taken,
    input  wire amber_pcc_pkg::addr_t     branch_pc,
    input  wire logic                     syscall,
    input  wire logic                     kret,
    input  wire logic                     csr_we,
    input  wire amber_pcc_pkg::csr_idx_t  csr_waddr,
    input  wire amber_pcc_pkg::data_t     csr_wdata,
    input  wire amber_pcc_pkg::csr_idx_t  csr_raddr,
    output amber_pcc_pkg::addr_t          pc,
    output logic                          fetch_ok,
    output logic                          mode_kernel,
    output amber_pcc_pkg::data_t          csr_rdata
);

    // Write word as seen by the decoding blocks
    amber_pcc_pkg::csr_word_u csr_word;

    assign csr_word = csr_wdata;

    // ------------------------------
    // Privilege state
    // ------------------------------
    priv_mode_fsm u_priv_mode_fsm (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .syscall    (syscall),
        .kret       (kret),
        .csr_we     (csr_we),
        .csr_waddr  (csr_waddr),
        .csr_wdata  (csr_word),
        .mode_kernel(mode_kernel)
    );

    // ------------------------------
    // Fetch PC
    // ------------------------------
    fetch_pc_counter u_fetch_pc_counter (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .stall       (stall),
        .branch_taken(branch_taken),
        .branch_pc   (branch_pc),
        .fetch_ok    (fetch_ok),
        .pc          (pc)
    );

    // ------------------------------
    // PCC window and CSR view
    // ------------------------------
    pcc_window #(
        .PCC_RESET_LEN(PCC_RESET_LEN)
    ) u_pcc_window (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .mode_kernel(mode_kernel),
        .pc         (pc),
        .csr_we     (csr_we),
        .csr_waddr  (csr_waddr),
        .csr_wdata  (csr_word),
        .csr_raddr  (csr_raddr),
        .fetch_ok   (fetch_ok),
        .csr_rdata  (csr_rdata)
    );

endmodule

`default_nettype wire

//--- rtl/pcc_window.sv
`timescale 1ns/1ns
`default_nettype none

module pcc_window #(
    parameter int unsigned PCC_RESET_LEN = 4096
) (
    input  wire                            iw_clk,
    input  wire                            iw_rst,
    input  wire logic                      mode_kernel,
    input  wire amber_pcc_pkg::addr_t      pc,
    input  wire logic                      csr_we,
    input  wire amber_pcc_pkg::csr_idx_t   csr_waddr,
    input  wire amber_pcc_pkg::csr_word_u  csr_wdata,
    input  wire amber_pcc_pkg::csr_idx_t   csr_raddr,
    output logic                           fetch_ok,
    output amber_pcc_pkg::data_t           csr_rdata
);

    localparam int HALF = amber_pcc_pkg::DATA_W;

    amber_pcc_pkg::addr_t base_q;
    amber_pcc_pkg::addr_t len_q;
    amber_pcc_pkg::data_t perms_q;
    logic                 tag_q;

    logic                      kernel_wr;
    logic [amber_pcc_pkg::ADDR_W:0] limit;
    logic                      in_bounds;

    assign kernel_wr = csr_we && mode_kernel;

    // ------------------------------
    // Window registers
    // ------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            base_q  <= amber_pcc_pkg::PCC_RESET_BASE;
            len_q   <= amber_pcc_pkg::addr_t'(PCC_RESET_LEN);
            perms_q <= amber_pcc_pkg::PCC_RESET_PERMS;
            tag_q   <= amber_pcc_pkg::PCC_RESET_TAG;
        end else if (kernel_wr) begin
            case (csr_waddr)
                amber_pcc_pkg::CSR_IDX_PCC_BASE_LO: begin
                    base_q[HALF-1:0] <= csr_wdata.half;
                end
                amber_pcc_pkg::CSR_IDX_PCC_BASE_HI: begin
                    base_q[2*HALF-1:HALF] <= csr_wdata.half;
                end
                amber_pcc_pkg::CSR_IDX_PCC_LEN_LO: begin
                    len_q[HALF-1:0] <= csr_wdata.half;
                end
                amber_pcc_pkg::CSR_IDX_PCC_LEN_HI: begin
                    len_q[2*HALF-1:HALF] <= csr_wdata.half;
                end
                amber_pcc_pkg::CSR_IDX_PCC_PERMS: begin
                    // Only the execute permission is defined
                    perms_q <= '0;
                    perms_q[amber_pcc_pkg::PERM_X_BIT] <= csr_wdata.flags.exec;
                end
                amber_pcc_pkg::CSR_IDX_PCC_TAG: begin
                    tag_q <= csr_wdata.flags.flag;
                end
                default: begin
                    // Cursor follows the PC, STATUS belongs to the mode FSM
                end
            endcase
        end
    end

    // ------------------------------
    // Fetch check
    // ------------------------------
    // One extra bit so a window at the top of memory does not wrap
    assign limit     = {1'b0, base_q} + {1'b0, len_q};
    assign in_bounds = (pc >= base_q) && ({1'b0, pc} < limit);
    assign fetch_ok  = tag_q && perms_q[amber_pcc_pkg::PERM_X_BIT] && in_bounds;

    // ------------------------------
    // CSR read view
    // ------------------------------
    always_comb begin
        case (csr_raddr)
            amber_pcc_pkg::CSR_IDX_STATUS: begin
                csr_rdata = amber_pcc_pkg::data_t'(mode_kernel);
            end
            amber_pcc_pkg::CSR_IDX_PCC_BASE_LO: csr_rdata = base_q[HALF-1:0];
            amber_pcc_pkg::CSR_IDX_PCC_BASE_HI: csr_rdata = base_q[2*HALF-1:HALF];
            amber_pcc_pkg::CSR_IDX_PCC_LEN_LO:  csr_rdata = len_q[HALF-1:0];
            amber_pcc_pkg::CSR_IDX_PCC_LEN_HI:  csr_rdata = len_q[2*HALF-1:HALF];
            // Cursor is the live fetch PC
            amber_pcc_pkg::CSR_IDX_PCC_CUR_LO:  csr_rdata = pc[HALF-1:0];
            amber_pcc_pkg::CSR_IDX_PCC_CUR_HI:  csr_rdata = pc[2*HALF-1:HALF];
            amber_pcc_pkg::CSR_IDX_PCC_PERMS:   csr_rdata = perms_q;
            amber_pcc_pkg::CSR_IDX_PCC_TAG: begin
                csr_rdata = amber_pcc_pkg::data_t'(tag_q);
            end
            default: csr_rdata = '0;
        endcase
    end

    // User mode cannot touch the window, whatever index it writes
    a_user_write_blocked: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        (csr_we && !mode_kernel) |=>
            $stable(base_q) && $stable(len_q) && $stable(perms_q) && $stable(tag_q)
    );

endmodule

`default_nettype wire

//--- rtl/fetch_pc_counter.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_counter (
    input  wire                          iw_clk,
    input  wire                          iw_rst,
    input  wire logic                    stall,
    input  wire logic                    branch_taken,
    input  wire amber_pcc_pkg::addr_t    branch_pc,
    input  wire logic                    fetch_ok,
    output amber_pcc_pkg::addr_t         pc
);

    // ------------------------------
    // Fetch PC
    // ------------------------------
    // Branch beats stall, stall beats the increment
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc <= amber_pcc_pkg::PC_RESET;
        end else if (branch_taken) begin
            pc <= branch_pc;
        end else if (!stall && fetch_ok) begin
            pc <= pc + amber_pcc_pkg::addr_t'(1);
        end
    end

    // A failed PCC check freezes fetch until a branch moves the PC
    a_hold_on_violation: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        (!branch_taken && !stall && !fetch_ok) |=> $stable(pc)
    );

endmodule

`default_nettype wire

//--- rtl/priv_mode_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module priv_mode_fsm (
    input  wire                            iw_clk,
    input  wire                            iw_rst,
    input  wire logic                      syscall,
    input  wire logic                      kret,
    input  wire logic                      csr_we,
    input  wire amber_pcc_pkg::csr_idx_t   csr_waddr,
    input  wire amber_pcc_pkg::csr_word_u  csr_wdata,
    output logic                           mode_kernel
);

    logic status_wr;
    logic mode_next;

    // STATUS is writable from kernel only, judged on the current mode
    assign status_wr = csr_we && mode_kernel &&
                       (csr_waddr == amber_pcc_pkg::CSR_IDX_STATUS);

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        mode_next = mode_kernel;
        if (status_wr) begin
            mode_next = csr_wdata.flags.flag;
        end
        // Trap entry and return override a STATUS write
        if (syscall) begin
            mode_next = 1'b1;
        end else if (kret) begin
            mode_next = 1'b0;
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            mode_kernel <= amber_pcc_pkg::MODE_RESET_KERNEL;
        end else begin
            mode_kernel <= mode_next;
        end
    end

    // Only one trap branch can retire per cycle
    a_one_trap: assert property (
        @(posedge iw_clk) disable iff (iw_rst) !(syscall && kret)
    );

endmodule

`default_nettype wire

//--- rtl/amber_pcc_pkg.sv
`default_nettype none

package amber_pcc_pkg;

    // ------------------------------
    // Widths and base types
    // ------------------------------
    localparam int ADDR_W    = 48;
    localparam int DATA_W    = 24;
    localparam int CSR_IDX_W = 8;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [CSR_IDX_W-1:0] csr_idx_t;

    // ------------------------------
    // CSR window indices
    // ------------------------------
    localparam csr_idx_t CSR_IDX_STATUS      = 8'h00;
    localparam csr_idx_t CSR_IDX_PCC_BASE_LO = 8'h10;
    localparam csr_idx_t CSR_IDX_PCC_BASE_HI = 8'h11;
    localparam csr_idx_t CSR_IDX_PCC_LEN_LO  = 8'h12;
    localparam csr_idx_t CSR_IDX_PCC_LEN_HI  = 8'h13;
    localparam csr_idx_t CSR_IDX_PCC_CUR_LO  = 8'h14;
    localparam csr_idx_t CSR_IDX_PCC_CUR_HI  = 8'h15;
    localparam csr_idx_t CSR_IDX_PCC_PERMS   = 8'h16;
    localparam csr_idx_t CSR_IDX_PCC_TAG     = 8'h17;

    // Execute permission inside the PERMS word
    localparam int PERM_X_BIT = 2;

    // Reset state of the fetch front end
    localparam addr_t PC_RESET          = '0;
    localparam logic  MODE_RESET_KERNEL = 1'b1;
    localparam addr_t PCC_RESET_BASE    = '0;
    localparam data_t PCC_RESET_PERMS   = data_t'(1) << PERM_X_BIT;
    localparam logic  PCC_RESET_TAG     = 1'b1;

    // Flag view of a CSR word, shared by PERMS, TAG and STATUS
    typedef struct packed {
        logic [20:0] rsvd_hi;
        logic        exec;
        logic        rsvd_lo;
        logic        flag;
    } csr_flags_t;

    // A written CSR word, read as an address half or as flags
    typedef union packed {
        data_t      half;
        csr_flags_t flags;
    } csr_word_u;

endpackage

`default_nettype wire
